// ==== Makefile ====
# Verilator build for the ad9434 receive interface

VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert
TB_TOP     ?= ad9434_rx_tb
RTL_TOP    ?= ad9434_rx_top
FILE_LIST  ?= ad9434_rx_top.f
OBJ_DIR    ?= obj_dir
SIM_LOG    ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TB_TOP) -f $(FILE_LIST)

$(OBJ_DIR)/V$(TB_TOP): $(FILE_LIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TB_TOP)
	-./$(OBJ_DIR)/V$(TB_TOP) > $(SIM_LOG) 2>&1
	@cat $(SIM_LOG)
	@grep -q "TEST OK" $(SIM_LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)

// ==== ad9434_rx_top.f ====
logic/ad9434_pkg.sv
logic/serdes_in_lane.sv
logic/delay_ctrl.sv
logic/ad9434_if.sv
logic/ad9434_rx_top.sv
tests/ad9434_rx_asserts.sv
tests/ad9434_rx_tb.sv

// ==== logic/ad9434_if.sv ====
/*
  ad9434 capture core, one 12-bit data lane and one over-range lane
  both lanes share the fast clock, the divided clock and the reset, so
  data and over-range words leave on the same adc_div_clk edge
*/
module ad9434_if #(
  parameter int DATA_WIDTH = ad9434_pkg::DATA_WIDTH_DEF,
  parameter int SERDES_FACTOR = ad9434_pkg::SERDES_FACTOR_DEF
) (
  input  logic adc_clk_in,
  input  logic adc_div_clk,
  input  logic adc_rst,
  input  logic [DATA_WIDTH-1:0] adc_data_in,
  input  logic adc_or_in,
  input  ad9434_pkg::tap_bus_t taps,
  input  logic delay_locked,
  input  logic clk_locked,
  output ad9434_pkg::adc_word_t adc_word,
  output logic adc_or,
  output logic adc_status
);

  // deserialized data, s0 in the top bits
  logic [SERDES_FACTOR*DATA_WIDTH-1:0] adc_data_s;
  // over-range bits, earliest in the top bit
  logic [SERDES_FACTOR-1:0] adc_or_s;
  logic adc_status_m1;

  // ******************************
  // capture lanes
  // ******************************

  // data pins use taps 0 to DATA_WIDTH-1
  serdes_in_lane #(
    .DATA_WIDTH(DATA_WIDTH),
    .SERDES_FACTOR(SERDES_FACTOR)
  ) i_adc_data (
    .adc_clk_in(adc_clk_in),
    .adc_div_clk(adc_div_clk),
    .adc_rst(adc_rst),
    .data_in(adc_data_in),
    .taps(taps[DATA_WIDTH-1:0]),
    .data_par(adc_data_s)
  );

  // over-range pin uses the tap right above the data taps
  serdes_in_lane #(
    .DATA_WIDTH(1),
    .SERDES_FACTOR(SERDES_FACTOR)
  ) i_adc_or (
    .adc_clk_in(adc_clk_in),
    .adc_div_clk(adc_div_clk),
    .adc_rst(adc_rst),
    .data_in(adc_or_in),
    .taps(taps[DATA_WIDTH:DATA_WIDTH]),
    .data_par(adc_or_s)
  );

  // word layout follows adc_word_t, samples first, or_bits last
  assign adc_word = {adc_data_s, adc_or_s};

  // any over-range sample in the word flags the whole word
  assign adc_or = |adc_or_s;

  // ******************************
  // status
  // ******************************

  // up only when the clock source and the delay block are both ready
  // two register stages, so status follows the inputs by two cycles
  always_ff @(posedge adc_div_clk) begin
    if (adc_rst) begin
      adc_status_m1 <= 1'b0;
      adc_status <= 1'b0;
    end else begin
      adc_status_m1 <= clk_locked & delay_locked;
      adc_status <= adc_status_m1;
    end
  end

endmodule

// ==== logic/ad9434_pkg.sv ====
/*
  shared types and default build values for the ad9434 receive path
  adc_word_t and tap_bus_t are sized for the default build only
  (12 data pins, 4:1 deserializer, one over-range pin)
*/
package ad9434_pkg;

  // ******************************
  // default build values
  // ******************************

  // converter data pins
  localparam int DATA_WIDTH_DEF = 12;

  // fast clock cycles per divided clock cycle
  localparam int SERDES_FACTOR_DEF = 4;

  // data pins plus the over-range pin
  localparam int NUM_PINS_DEF = 13;

  // divided cycles from reset release until the delay block reports ready
  localparam int LOCK_CYCLES_DEF = 8;

  // ******************************
  // types
  // ******************************

  // one converter sample
  typedef logic [DATA_WIDTH_DEF-1:0] sample_t;

  // delay setting in fast clock cycles, 0 to 7
  typedef logic [2:0] tap_t;

  // pin index, 0 to 11 are data bits, 12 is over-range
  typedef logic [3:0] pin_sel_t;

  // one deserialized word
  // s0 is the earliest sample and sits in the top bits
  typedef struct packed {
    sample_t s0;
    sample_t s1;
    sample_t s2;
    sample_t s3;
    logic [SERDES_FACTOR_DEF-1:0] or_bits;
  } adc_word_t;

  // one tap per delayed pin, index matches pin_sel_t
  typedef tap_t [NUM_PINS_DEF-1:0] tap_bus_t;

endpackage

// ==== logic/ad9434_rx_top.sv ====
/*
  ad9434 receive interface, capture core plus tap control
  both clocks come from outside with aligned rising edges and a 4:1 ratio
  clk_locked stands in for the lock output of the clock source
*/
module ad9434_rx_top #(
  parameter int DATA_WIDTH = ad9434_pkg::DATA_WIDTH_DEF,
  parameter int SERDES_FACTOR = ad9434_pkg::SERDES_FACTOR_DEF,
  parameter int LOCK_CYCLES = ad9434_pkg::LOCK_CYCLES_DEF
) (
  input  logic adc_clk_in,
  input  logic adc_div_clk,
  input  logic adc_rst,
  input  logic [DATA_WIDTH-1:0] adc_data_in,
  input  logic adc_or_in,
  input  logic clk_locked,
  input  logic delay_req,
  input  logic delay_wr,
  input  ad9434_pkg::pin_sel_t delay_sel,
  input  ad9434_pkg::tap_t delay_wtap,
  output logic delay_ack,
  output ad9434_pkg::tap_t delay_rtap,
  output logic delay_locked,
  output logic [SERDES_FACTOR*DATA_WIDTH-1:0] adc_data,
  output logic adc_or,
  output logic adc_status
);

  import ad9434_pkg::*;

  tap_bus_t taps;
  adc_word_t adc_word;

  // tap registers, one per data pin plus over-range
  delay_ctrl #(
    .NUM_PINS(DATA_WIDTH + 1),
    .LOCK_CYCLES(LOCK_CYCLES)
  ) i_delay_ctrl (
    .adc_div_clk(adc_div_clk),
    .adc_rst(adc_rst),
    .delay_req(delay_req),
    .delay_wr(delay_wr),
    .delay_sel(delay_sel),
    .delay_wtap(delay_wtap),
    .delay_ack(delay_ack),
    .delay_rtap(delay_rtap),
    .taps(taps),
    .delay_locked(delay_locked)
  );

  // capture core
  ad9434_if #(
    .DATA_WIDTH(DATA_WIDTH),
    .SERDES_FACTOR(SERDES_FACTOR)
  ) i_adc_if (
    .adc_clk_in(adc_clk_in),
    .adc_div_clk(adc_div_clk),
    .adc_rst(adc_rst),
    .adc_data_in(adc_data_in),
    .adc_or_in(adc_or_in),
    .taps(taps),
    .delay_locked(delay_locked),
    .clk_locked(clk_locked),
    .adc_word(adc_word),
    .adc_or(adc_or),
    .adc_status(adc_status)
  );

  // four samples, earliest in the top bits
  assign adc_data = {adc_word.s0, adc_word.s1, adc_word.s2, adc_word.s3};

endmodule

// ==== logic/delay_ctrl.sv ====
/*
  tap register file with a four-phase req/ack access port, on adc_div_clk
  a new request may start only once delay_ack is low again
  a delay_sel of NUM_PINS or more writes nothing and reads back zero
*/
module delay_ctrl #(
  parameter int NUM_PINS = ad9434_pkg::NUM_PINS_DEF,
  parameter int LOCK_CYCLES = ad9434_pkg::LOCK_CYCLES_DEF
) (
  input  logic adc_div_clk,
  input  logic adc_rst,
  input  logic delay_req,
  input  logic delay_wr,
  input  ad9434_pkg::pin_sel_t delay_sel,
  input  ad9434_pkg::tap_t delay_wtap,
  output logic delay_ack,
  output ad9434_pkg::tap_t delay_rtap,
  output ad9434_pkg::tap_bus_t taps,
  output logic delay_locked
);

  localparam int LCW = $clog2(LOCK_CYCLES + 1);

  // handshake states
  typedef enum logic [1:0] {
    idle,
    wait_ack,
    wait_release
  } hs_state_t;

  hs_state_t state;
  logic sel_valid;
  logic [LCW-1:0] lock_cnt;

  // ******************************
  // readback
  // ******************************

  assign sel_valid = (int'(delay_sel) < NUM_PINS);

  // combinational read, so a write is already visible when ack rises
  assign delay_rtap = sel_valid ? taps[delay_sel] : '0;

  // ******************************
  // handshake and tap writes
  // ******************************

  always_ff @(posedge adc_div_clk) begin
    if (adc_rst) begin
      state <= idle;
      delay_ack <= 1'b0;
      taps <= '0;
    end else begin
      case (state)
        idle: begin
          // write on the first edge that sees req
          if (delay_req) begin
            if (delay_wr && sel_valid) begin
              taps[delay_sel] <= delay_wtap;
            end
            state <= wait_ack;
          end
        end
        wait_ack: begin
          // ack one cycle after the write
          delay_ack <= 1'b1;
          state <= wait_release;
        end
        wait_release: begin
          // hold ack until the requester lets go
          if (!delay_req) begin
            delay_ack <= 1'b0;
            state <= idle;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // ******************************
  // delay ready
  // ******************************

  // stands in for the IDELAYCTRL ready flag
  // rises LOCK_CYCLES edges after reset release and stays up
  always_ff @(posedge adc_div_clk) begin
    if (adc_rst) begin
      lock_cnt <= '0;
      delay_locked <= 1'b0;
    end else if (!delay_locked) begin
      lock_cnt <= lock_cnt + 1'b1;
      if (lock_cnt == LCW'(LOCK_CYCLES - 1)) begin
        delay_locked <= 1'b1;
      end
    end
  end

endmodule

// ==== logic/serdes_in_lane.sv ====
/*
  single-ended capture lane with a per-pin tap delay and a 1:SERDES_FACTOR deserializer
  adc_clk_in and adc_div_clk rise together, SERDES_FACTOR is 3 or more
  adc_rst must change right after a rising adc_div_clk edge because the
  word phase is taken from the reset release
*/
module serdes_in_lane #(
  parameter int DATA_WIDTH = ad9434_pkg::DATA_WIDTH_DEF,
  parameter int SERDES_FACTOR = ad9434_pkg::SERDES_FACTOR_DEF
) (
  input  logic adc_clk_in,
  input  logic adc_div_clk,
  input  logic adc_rst,
  input  logic [DATA_WIDTH-1:0] data_in,
  input  ad9434_pkg::tap_t [DATA_WIDTH-1:0] taps,
  output logic [SERDES_FACTOR*DATA_WIDTH-1:0] data_par
);

  import ad9434_pkg::*;

  // one delay stage per possible tap value
  localparam int DLY_DEPTH = 2 ** $bits(tap_t);
  localparam int PW = $clog2(SERDES_FACTOR);
  localparam logic [PW-1:0] PHASE_LAST = PW'(SERDES_FACTOR - 1);

  logic rst_m1;
  logic rst_fast;
  logic [DATA_WIDTH-1:0] dly_line [DLY_DEPTH];
  logic [DATA_WIDTH-1:0] dly_out;
  logic [SERDES_FACTOR-1:0][DATA_WIDTH-1:0] shift_q;
  logic [SERDES_FACTOR*DATA_WIDTH-1:0] snap_q;
  logic [PW-1:0] phase;

  // ******************************
  // fast clock domain
  // ******************************

  // reset copy for the fast domain
  // releases two fast edges after adc_rst falls
  always_ff @(posedge adc_clk_in) begin
    rst_m1 <= adc_rst;
    rst_fast <= rst_m1;
  end

  // delay line, stage 0 is the pin registered once
  always_ff @(posedge adc_clk_in) begin
    dly_line[0] <= data_in;
    for (int k = 1; k < DLY_DEPTH; k++) begin
      dly_line[k] <= dly_line[k-1];
    end
  end

  // each bit picks its own stage
  // a new tap is seen by the shift register on the next fast edge
  always_comb begin
    for (int b = 0; b < DATA_WIDTH; b++) begin
      dly_out[b] = dly_line[taps[b]][b];
    end
  end

  // newest sample enters at slot SERDES_FACTOR-1 (bottom)
  // so the oldest one ends up in the top bits
  always_ff @(posedge adc_clk_in) begin
    shift_q <= {shift_q[SERDES_FACTOR-2:0], dly_out};
  end

  // phase counter starts with the fast reset release
  // snapshot on the last phase, when the shift register holds one
  // full group of samples, two fast edges ahead of the divided edge
  always_ff @(posedge adc_clk_in) begin
    if (rst_fast) begin
      phase <= '0;
      snap_q <= '0;
    end else begin
      if (phase == PHASE_LAST) begin
        phase <= '0;
        snap_q <= shift_q;
      end else begin
        phase <= phase + 1'b1;
      end
    end
  end

  // ******************************
  // divided clock domain
  // ******************************

  // snapshot is stable across the divided edge, so a plain register is enough
  // total latency is two divided cycles with all taps at zero
  always_ff @(posedge adc_div_clk) begin
    if (adc_rst) begin
      data_par <= '0;
    end else begin
      data_par <= snap_q;
    end
  end

endmodule

// ==== tests/ad9434_rx_asserts.sv ====
/*
  lane checks bound into every serdes_in_lane instance
  assumes both clocks rise together with a 4:1 ratio
*/
module ad9434_rx_asserts #(
  parameter int DATA_WIDTH = ad9434_pkg::DATA_WIDTH_DEF,
  parameter int SERDES_FACTOR = ad9434_pkg::SERDES_FACTOR_DEF
) (
  input logic adc_clk_in,
  input logic adc_div_clk,
  input logic adc_rst,
  input ad9434_pkg::tap_t [DATA_WIDTH-1:0] taps,
  input logic [SERDES_FACTOR*DATA_WIDTH-1:0] data_par
);

  import ad9434_pkg::*;

  // ******************************
  // reset and tap rules
  // ******************************

  // the word register clears on every divided edge that sees reset
  a_rst_clear: assert property (
    @(posedge adc_div_clk) adc_rst |=> (data_par == '0)
  ) else $error("lane output is not zero while reset is high");

  // tap registers live on the divided clock
  // seen from the fast clock a change follows a rising divided clock
  a_tap_stable: assert property (
    @(posedge adc_clk_in) (taps != $past(taps)) |-> $rose(adc_div_clk)
  ) else $error("lane taps changed away from a divided clock edge");

endmodule

// ==== tests/ad9434_rx_tb.sv ====
/*
  testbench for the ad9434 receive top level
  both clocks rise together, fast period 10, divided period 40
  expected words come from a pin history and the latency rule,
  slot j of word m is the pin value of fast cycle 4(m-2)+j-tap
*/
module ad9434_rx_tb;

  import ad9434_pkg::*;

  localparam int RST_CYCLES = 3;
  // fast edge index of the reset release edge
  localparam int FAST_BASE = 4 * RST_CYCLES;
  localparam int HIST_LEN = 16384;
  localparam int TMO = 400;

  logic adc_clk_in = 1'b1;
  logic adc_div_clk = 1'b1;
  logic adc_rst = 1'b1;
  logic [11:0] adc_data_in = '0;
  logic adc_or_in = 1'b0;
  logic clk_locked = 1'b1;
  logic delay_req = 1'b0;
  logic delay_wr = 1'b0;
  pin_sel_t delay_sel = '0;
  tap_t delay_wtap = '0;
  logic delay_ack;
  tap_t delay_rtap;
  logic delay_locked;
  logic [47:0] adc_data;
  logic adc_or;
  logic adc_status;

  integer seed = 32'h56ad_c8b2;
  logic [11:0] hist_d [HIST_LEN];
  logic hist_or [HIST_LEN];
  tap_t tap_model [NUM_PINS_DEF];
  int div_edges = 0;
  logic check_en = 1'b0;
  int resume_m = 0;
  int words_checked = 0;
  int or_words = 0;
  logic or_random = 1'b0;
  logic or_pulse_req = 1'b0;
  string test_name = "reset";

  ad9434_rx_top i_dut (
    .adc_clk_in(adc_clk_in), .adc_div_clk(adc_div_clk), .adc_rst(adc_rst),
    .adc_data_in(adc_data_in), .adc_or_in(adc_or_in), .clk_locked(clk_locked),
    .delay_req(delay_req), .delay_wr(delay_wr), .delay_sel(delay_sel),
    .delay_wtap(delay_wtap), .delay_ack(delay_ack), .delay_rtap(delay_rtap),
    .delay_locked(delay_locked), .adc_data(adc_data), .adc_or(adc_or),
    .adc_status(adc_status)
  );

  bind serdes_in_lane ad9434_rx_asserts #(
    .DATA_WIDTH(DATA_WIDTH), .SERDES_FACTOR(SERDES_FACTOR)
  ) i_lane_asserts (
    .adc_clk_in(adc_clk_in), .adc_div_clk(adc_div_clk), .adc_rst(adc_rst),
    .taps(taps), .data_par(data_par)
  );

  // ******************************
  // clocks and pin stimulus
  // ******************************

  always #5 adc_clk_in = ~adc_clk_in;
  always #20 adc_div_clk = ~adc_div_clk;

  always @(posedge adc_div_clk) begin
    div_edges = div_edges + 1;
  end

  // fast edge n sits at time 10n, each driven value logged under n
  always @(posedge adc_clk_in) begin
    int idx;
    logic [11:0] d;
    logic o;
    idx = int'($time / 10);
    d = 12'($random(seed));
    o = 1'b0;
    if (or_pulse_req) begin
      // single fast cycle pulse
      o = 1'b1;
      or_pulse_req = 1'b0;
    end else if (or_random) begin
      o = (($random(seed) & 7) == 0);
    end
    adc_data_in <= d;
    adc_or_in <= o;
    if (idx < HIST_LEN) begin
      hist_d[idx] = d;
      hist_or[idx] = o;
    end
  end

  // ******************************
  // reference model and reporting
  // ******************************

  function automatic void ref_word(input int m, output logic [47:0] d, output logic o);
    int idx;
    d = '0;
    o = 1'b0;
    for (int j = 0; j < 4; j++) begin
      for (int b = 0; b < 12; b++) begin
        idx = FAST_BASE + 4 * (m - 2) + j - int'(tap_model[b]);
        d[(3 - j) * 12 + b] = hist_d[idx][b];
      end
      idx = FAST_BASE + 4 * (m - 2) + j - int'(tap_model[12]);
      o = o | hist_or[idx];
    end
  endfunction

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] exp, act);
    $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    fail_run("value mismatch");
  endtask

  task automatic check_equal(input string name, input logic [63:0] exp, act);
    assert (exp === act) else report_mismatch(name, exp, act);
  endtask

  // compares every word once checking is enabled and taps are settled
  always @(negedge adc_div_clk) begin
    int m;
    logic [47:0] exp_d;
    logic exp_o;
    m = div_edges - RST_CYCLES;
    if (check_en && m >= resume_m) begin
      ref_word(m, exp_d, exp_o);
      assert (adc_data === exp_d) else report_mismatch({test_name, " data"}, 64'(exp_d),
                                                        64'(adc_data));
      assert (adc_or === exp_o) else report_mismatch({test_name, " or"}, 64'(exp_o),
                                                      64'(adc_or));
      words_checked = words_checked + 1;
      if (adc_or) begin
        or_words = or_words + 1;
      end
    end
  end

  // ******************************
  // waits and tap access
  // ******************************

  task automatic wait_words(input int n);
    int target;
    int cnt;
    target = words_checked + n;
    cnt = 0;
    while (words_checked < target && cnt < n + TMO) begin
      @(negedge adc_div_clk);
      cnt++;
    end
    if (words_checked < target) fail_run("timeout waiting for checked words");
  endtask

  // one four-phase access, readback compared with exp_rtap
  task automatic tap_access(input int sel, input logic wr, input tap_t wtap,
                            input tap_t exp_rtap);
    int cnt;
    tap_t rtap;
    @(posedge adc_div_clk);
    check_en = 1'b0;
    delay_req <= 1'b1;
    delay_wr <= wr;
    delay_sel <= pin_sel_t'(sel);
    delay_wtap <= wtap;
    cnt = 0;
    do begin
      @(negedge adc_div_clk);
      cnt++;
    end while (!delay_ack && cnt < TMO);
    if (!delay_ack) fail_run("timeout waiting for delay_ack to rise");
    rtap = delay_rtap;
    check_equal($sformatf("%s readback sel %0d", test_name, sel), 64'(exp_rtap), 64'(rtap));
    @(posedge adc_div_clk);
    delay_req <= 1'b0;
    cnt = 0;
    do begin
      @(negedge adc_div_clk);
      cnt++;
    end while (delay_ack && cnt < TMO);
    if (delay_ack) fail_run("timeout waiting for delay_ack to fall");
    if (wr && sel < NUM_PINS_DEF) begin
      tap_model[sel] = wtap;
    end
    // words that mix old and new taps are skipped
    resume_m = div_edges - RST_CYCLES + 3;
    check_en = 1'b1;
  endtask

  // ******************************
  // test sequence
  // ******************************

  initial begin
    int cnt;
    int m;
    for (int i = 0; i < HIST_LEN; i++) begin
      hist_d[i] = '0;
      hist_or[i] = 1'b0;
    end
    for (int p = 0; p < NUM_PINS_DEF; p++) begin
      tap_model[p] = '0;
    end
    repeat (RST_CYCLES) @(posedge adc_div_clk);
    adc_rst <= 1'b0;

    // reset values and delay ready
    @(negedge adc_div_clk);
    check_equal("reset status", 0, 64'(adc_status));
    check_equal("reset ack", 0, 64'(delay_ack));
    check_equal("reset or", 0, 64'(adc_or));
    check_equal("reset data", 0, 64'(adc_data));
    test_name = "lock";
    cnt = 0;
    while (!delay_locked && cnt < TMO) begin
      @(negedge adc_div_clk);
      cnt++;
    end
    if (!delay_locked) fail_run("timeout waiting for delay_locked");
    m = div_edges - RST_CYCLES;
    check_equal("lock cycles", 64'(LOCK_CYCLES_DEF), 64'(m));

    // status follows the lock inputs by two cycles
    test_name = "status";
    @(negedge adc_div_clk);
    check_equal("status one cycle after lock", 0, 64'(adc_status));
    @(negedge adc_div_clk);
    check_equal("status two cycles after lock", 1, 64'(adc_status));
    @(posedge adc_div_clk);
    clk_locked <= 1'b0;
    @(negedge adc_div_clk);
    @(negedge adc_div_clk);
    check_equal("status one cycle after clk drop", 1, 64'(adc_status));
    @(negedge adc_div_clk);
    check_equal("status two cycles after clk drop", 0, 64'(adc_status));
    @(posedge adc_div_clk);
    clk_locked <= 1'b1;

    // plain data stream, all taps zero
    test_name = "stream";
    resume_m = div_edges - RST_CYCLES + 1;
    check_en = 1'b1;
    wait_words(200);

    // random over-range pulses, then one lone pulse
    test_name = "overrange";
    @(negedge adc_div_clk);
    or_random = 1'b1;
    wait_words(100);
    @(negedge adc_div_clk);
    or_random = 1'b0;
    wait_words(4);
    or_words = 0;
    @(negedge adc_div_clk);
    or_pulse_req = 1'b1;
    wait_words(20);
    check_equal("lone pulse word count", 1, 64'(or_words));

    // tap writes, readback and delayed streams
    test_name = "taps";
    tap_access(4, 1'b1, 3'd3, 3'd3);
    wait_words(40);
    tap_access(12, 1'b1, 3'd5, 3'd5);
    or_random = 1'b1;
    wait_words(60);
    for (int p = 0; p < NUM_PINS_DEF; p++) begin
      tap_access(p, 1'b0, 3'd0, tap_model[p]);
    end
    tap_access(13, 1'b1, 3'd6, 3'd0);
    wait_words(40);

    $display("TEST OK");
    $finish;
  end

endmodule
